//--- verif/icache_golden.txt
# op  arg(F,X: pc  I: set)  instr(I: way)  adef  new ar bursts
# X fetches arg, flushes it during the refill and expects no response
F 00001010 5a5a1010 0 1
F 00001014 5a5a1014 0 0
F 00001018 5a5a1018 0 0
F 0000101c 5a5a101c 0 0
F 00001012 00000000 1 0
F 00002014 5a5a2014 0 1
F 00001018 5a5a1018 0 0
F 0010301c 5a4a301c 0 1
F 00001010 5a5a1010 0 0
F 00002010 5a5a2010 0 1
I 00000001 00000000 0 0
F 00001014 5a5a1014 0 1
X 00004020 00000000 0 1
F 00004028 5a5a4028 0 1
F 00004024 5a5a4024 0 0
F 00004021 00000000 1 0

//--- icache.f
+incdir+src
src/icache_pkg.sv
src/sdp_ram.sv
src/icache_way_array.sv
src/icache_ctrl.sv
src/icache_top.sv
verif/tb_mem_model.sv
verif/tb_icache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the icache testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -f icache.f -o sim_icache; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_icache > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verif/tb_icache.sv
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  localparam int HALF_PERIOD     = 20;
  localparam int SETTLE          = 10;
  localparam int WAIT_LIMIT      = 40;
  localparam int CYCLES_PER_LINE = 64;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       flush;
  fetch_req_t fetch_req;
  inv_req_t   inv_req;
  logic       req_ready;
  fetch_rsp_t fetch_rsp;
  logic       rsp_ready = 1'b1;
  axi_ar_t    ar_req;
  logic       ar_ready;
  axi_r_t     r_beat;
  logic       r_ready;
  logic       ar_stall = 1'b0;
  int         ar_count;

  logic [31:0] lfsr_state = 32'h1723;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          test_err;
  int          n_pass;
  int          n_fail;

  // golden columns
  byte    op_q[$];
  addr_t  arg_q[$];
  instr_t exp_q[$];
  logic   adef_q[$];
  int     ar_q[$];

  icache_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .fetch_req_i (fetch_req),
    .inv_req_i   (inv_req),
    .req_ready_o (req_ready),
    .fetch_rsp_o (fetch_rsp),
    .rsp_ready_i (rsp_ready),
    .ar_o        (ar_req),
    .ar_ready_i  (ar_ready),
    .r_i         (r_beat),
    .r_ready_o   (r_ready)
  );

  tb_mem_model u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar_req),
    .ar_ready_o (ar_ready),
    .r_o        (r_beat),
    .r_ready_i  (r_ready),
    .ar_stall_i (ar_stall),
    .ar_count_o (ar_count)
  );

  always #(HALF_PERIOD) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ============================================================
  // random stalls
  // ============================================================

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  always @(negedge clk) begin
    lfsr_state = lfsr_next(lfsr_state);
    rsp_ready <= lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    ar_stall  <= lfsr_state[0];
  end

  // ============================================================
  // compare tasks
  // ============================================================

  task automatic verify_instr(input string name, input instr_t expected, input instr_t actual);
    if (actual !== expected) begin
      $display("** Error: %s instr expected %08h actual %08h", name, expected, actual);
      test_err++;
    end
  endtask

  task automatic check_adef(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error: %s adef expected %0b actual %0b", name, expected, actual);
      test_err++;
    end
  endtask

  task automatic expect_pc(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("** Error: %s pc expected %08h actual %08h", name, expected, actual);
      test_err++;
    end
  endtask

  task automatic inspect_ar(input string name, input axi_ar_t expected, input axi_ar_t actual);
    if (actual !== expected) begin
      $display("** Error: %s ar request expected %h actual %h", name, expected, actual);
      test_err++;
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error: %s ar bursts expected %0d actual %0d", name, expected, actual);
      test_err++;
    end
  endtask

  // a refill reads the whole aligned line as one four-beat word burst
  function automatic axi_ar_t burst_for_line(input addr_t pc);
    axi_ar_t ar;
    ar.valid = 1'b1;
    ar.addr  = pc & 32'hffff_fff0;
    ar.len   = 8'd3;
    ar.size  = 3'b010;
    ar.burst = 2'b01;
    return ar;
  endfunction

  // ============================================================
  // operations, each entered and left on a falling edge
  // ============================================================

  task automatic run_fetch(input string name, input addr_t pc, input instr_t exp_instr,
                           input logic exp_adef, input int exp_ar);
    int         ar_before;
    int         waited;
    logic       accepted;
    logic       answered;
    fetch_rsp_t rsp;
    axi_ar_t    ar_exp;
    ar_before       = ar_count;
    waited          = 0;
    accepted        = 1'b0;
    answered        = 1'b0;
    rsp             = '0;
    ar_exp          = burst_for_line(pc);
    fetch_req.valid = 1'b1;
    fetch_req.pc    = pc;
    while (!accepted && waited < WAIT_LIMIT) begin
      #(SETTLE);
      accepted = req_ready;
      @(negedge clk);
      waited++;
    end
    fetch_req = '0;
    while (accepted && !answered && waited < WAIT_LIMIT) begin
      #(SETTLE);
      if (ar_req.valid && ar_ready) begin
        inspect_ar(name, ar_exp, ar_req);
      end
      if (fetch_rsp.valid && rsp_ready) begin
        answered = 1'b1;
        rsp      = fetch_rsp;
      end
      @(negedge clk);
      waited++;
    end
    if (!accepted) begin
      $display("%s: the cache never accepted the request", name);
      test_err++;
    end else if (!answered) begin
      $display("%s: no response within %0d cycles", name, WAIT_LIMIT);
      test_err++;
    end else begin
      verify_instr(name, exp_instr, rsp.instr);
      check_adef(name, exp_adef, rsp.adef);
      expect_pc(name, pc, rsp.pc);
    end
    compare_count(name, exp_ar, ar_count - ar_before);
  endtask

  task automatic run_invalidate(input string name, input idx_t idx, input way_t way);
    int   waited;
    logic accepted;
    waited        = 0;
    accepted      = 1'b0;
    inv_req.valid = 1'b1;
    inv_req.idx   = idx;
    inv_req.way   = way;
    while (!accepted && waited < WAIT_LIMIT) begin
      #(SETTLE);
      accepted = req_ready;
      @(negedge clk);
      waited++;
    end
    inv_req = '0;
    if (!accepted) begin
      $display("%s: the cache never accepted the invalidate", name);
      test_err++;
    end
  endtask

  // miss on pc, then kill it while the burst is running
  task automatic run_flush(input string name, input addr_t pc, input int exp_ar);
    int      ar_before;
    int      waited;
    logic    accepted;
    logic    refilling;
    logic    drained;
    logic    spurious;
    axi_ar_t ar_exp;
    ar_before       = ar_count;
    waited          = 0;
    accepted        = 1'b0;
    refilling       = 1'b0;
    drained         = 1'b0;
    spurious        = 1'b0;
    ar_exp          = burst_for_line(pc);
    fetch_req.valid = 1'b1;
    fetch_req.pc    = pc;
    while (!accepted && waited < WAIT_LIMIT) begin
      #(SETTLE);
      accepted = req_ready;
      @(negedge clk);
      waited++;
    end
    fetch_req = '0;
    while (accepted && !refilling && waited < WAIT_LIMIT) begin
      #(SETTLE);
      if (ar_req.valid && ar_ready) begin
        inspect_ar(name, ar_exp, ar_req);
      end
      refilling = r_ready;
      spurious  = spurious || fetch_rsp.valid;
      @(negedge clk);
      waited++;
    end
    if (refilling) begin
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
    end
    while (refilling && !drained && waited < WAIT_LIMIT) begin
      #(SETTLE);
      spurious = spurious || fetch_rsp.valid;
      drained  = req_ready;
      @(negedge clk);
      waited++;
    end
    if (!accepted) begin
      $display("%s: the cache never accepted the request", name);
      test_err++;
    end else if (!refilling) begin
      $display("%s: the refill never started", name);
      test_err++;
    end else if (!drained) begin
      $display("%s: the cache did not return to idle after the flush", name);
      test_err++;
    end
    if (spurious) begin
      $display("%s: a response came back for the flushed fetch", name);
      test_err++;
    end
    compare_count(name, exp_ar, ar_count - ar_before);
  endtask

  task automatic load_golden(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    ok = 1'b0;
    fd = $fopen("verif/icache_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
          if (n == 4) begin
            op_q.push_back(line.getc(0));
            arg_q.push_back(a);
            exp_q.push_back(b);
            adef_q.push_back(c[0]);
            ar_q.push_back(int'(d));
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  task automatic close_test(input string name);
    if (test_err == 0) begin
      n_pass++;
      $display("%s ok", name);
    end else begin
      n_fail++;
      $display("%s FAILED with %0d errors", name, test_err);
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial begin
    bit    ok;
    string name;
    rst_n     = 1'b0;
    flush     = 1'b0;
    fetch_req = '0;
    inv_req   = '0;
    n_pass    = 0;
    n_fail    = 0;
    load_golden(ok);
    if (!ok) begin
      $display("golden file verif/icache_golden.txt could not be read");
      $display("STATUS: FAIL");
    end else begin
      cycle_limit = CYCLES_PER_LINE * op_q.size();
      repeat (4) @(negedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      for (int i = 0; i < op_q.size(); i++) begin
        test_err = 0;
        case (op_q[i])
          "F": begin
            name = $sformatf("fetch_%02d", i);
            run_fetch(name, arg_q[i], exp_q[i], adef_q[i], ar_q[i]);
          end
          "I": begin
            name = $sformatf("inval_%02d", i);
            run_invalidate(name, idx_t'(arg_q[i]), way_t'(exp_q[i]));
          end
          "X": begin
            name = $sformatf("flush_%02d", i);
            run_flush(name, arg_q[i], ar_q[i]);
          end
          default: begin
            name = $sformatf("line_%02d", i);
            $display("%s: unknown operation in the golden file", name);
            test_err++;
          end
        endcase
        close_test(name);
      end
      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0 && n_pass == op_q.size()) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
    end
    $display("run stopped at the limit of %0d cycles", cycle_limit);
    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model import icache_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  input  logic    r_ready_i,
  input  logic    ar_stall_i,
  output int      ar_count_o
);

  logic       busy_q;
  addr_t      addr_q;
  logic [7:0] beats_left_q;

  // every word is its own address with the upper half scrambled
  function automatic instr_t mem_word(input addr_t a);
    return a ^ 32'h5A5A0000;
  endfunction

  // handshakes are taken on the rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q       <= 1'b0;
      addr_q       <= '0;
      beats_left_q <= '0;
      ar_count_o   <= 0;
    end else if (!busy_q) begin
      if (ar_i.valid && ar_ready_o) begin
        busy_q       <= 1'b1;
        addr_q       <= ar_i.addr;
        beats_left_q <= ar_i.len;
        ar_count_o   <= ar_count_o + 1;
      end
    end else if (r_o.valid && r_ready_i) begin
      addr_q       <= addr_q + 32'd4;
      beats_left_q <= beats_left_q - 8'd1;
      if (beats_left_q == 8'd0) begin
        busy_q <= 1'b0;
      end
    end
  end

  // outputs move on the falling edge, one burst at a time
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o <= 1'b0;
      r_o        <= '0;
    end else begin
      ar_ready_o <= !busy_q && !ar_stall_i;
      r_o.valid  <= busy_q;
      r_o.data   <= busy_q ? mem_word(addr_q) : '0;
      r_o.last   <= busy_q && (beats_left_q == 8'd0);
    end
  end

endmodule

//--- src/icache_top.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  fetch_req_t fetch_req_i,
  input  inv_req_t   inv_req_i,
  output logic       req_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       rsp_ready_i,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  input  axi_r_t     r_i,
  output logic       r_ready_o
);

  idx_t                        raddr;
  idx_t                        waddr;
  logic [`ICACHE_WAY_NUM-1:0]  tag_we;
  logic [`ICACHE_WAY_NUM-1:0]  valid_we;
  logic [`ICACHE_WAY_NUM-1:0]  data_we;
  tag_t                        tag_wdata;
  logic                        valid_wdata;
  line_t                       data_wdata;
  logic                        plru_we;
  way_t                        plru_wdata;
  tag_t  [`ICACHE_WAY_NUM-1:0] tag_rdata;
  logic  [`ICACHE_WAY_NUM-1:0] valid_rdata;
  line_t [`ICACHE_WAY_NUM-1:0] data_rdata;
  way_t                        plru_rdata;

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .inv_req_i     (inv_req_i),
    .req_ready_o   (req_ready_o),
    .fetch_rsp_o   (fetch_rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .ar_o          (ar_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_ready_o     (r_ready_o),
    .raddr_o       (raddr),
    .waddr_o       (waddr),
    .tag_we_o      (tag_we),
    .valid_we_o    (valid_we),
    .data_we_o     (data_we),
    .tag_wdata_o   (tag_wdata),
    .valid_wdata_o (valid_wdata),
    .data_wdata_o  (data_wdata),
    .plru_we_o     (plru_we),
    .plru_wdata_o  (plru_wdata),
    .tag_rdata_i   (tag_rdata),
    .valid_rdata_i (valid_rdata),
    .data_rdata_i  (data_rdata),
    .plru_rdata_i  (plru_rdata)
  );

  icache_way_array u_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .raddr_i       (raddr),
    .waddr_i       (waddr),
    .tag_we_i      (tag_we),
    .valid_we_i    (valid_we),
    .data_we_i     (data_we),
    .tag_wdata_i   (tag_wdata),
    .valid_wdata_i (valid_wdata),
    .data_wdata_i  (data_wdata),
    .plru_we_i     (plru_we),
    .plru_wdata_i  (plru_wdata),
    .tag_rdata_o   (tag_rdata),
    .valid_rdata_o (valid_rdata),
    .data_rdata_o  (data_rdata),
    .plru_rdata_o  (plru_rdata)
  );

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush_i,
  // fetch side
  input  fetch_req_t                  fetch_req_i,
  input  inv_req_t                    inv_req_i,
  output logic                        req_ready_o,
  output fetch_rsp_t                  fetch_rsp_o,
  input  logic                        rsp_ready_i,
  // axi read channels
  output axi_ar_t                     ar_o,
  input  logic                        ar_ready_i,
  input  axi_r_t                      r_i,
  output logic                        r_ready_o,
  // array ports
  output idx_t                        raddr_o,
  output idx_t                        waddr_o,
  output logic [`ICACHE_WAY_NUM-1:0]  tag_we_o,
  output logic [`ICACHE_WAY_NUM-1:0]  valid_we_o,
  output logic [`ICACHE_WAY_NUM-1:0]  data_we_o,
  output tag_t                        tag_wdata_o,
  output logic                        valid_wdata_o,
  output line_t                       data_wdata_o,
  output logic                        plru_we_o,
  output way_t                        plru_wdata_o,
  input  tag_t  [`ICACHE_WAY_NUM-1:0] tag_rdata_i,
  input  logic  [`ICACHE_WAY_NUM-1:0] valid_rdata_i,
  input  line_t [`ICACHE_WAY_NUM-1:0] data_rdata_i,
  input  way_t                        plru_rdata_i
);

  cache_state_e state_q;

  logic  s1_fetch_q;
  logic  s1_inv_q;
  logic  s1_adef_q;
  addr_t s1_pc_q;
  idx_t  s1_idx_q;
  way_t  s1_way_q;
  way_t  victim_q;
  ofs_t  beat_cnt_q;
  line_t line_buf_q;

  logic  s0_adef;
  logic  acc_inv;
  logic  acc_fetch;
  logic  s1_ready;
  logic  rsp_fire;
  logic  refill_we;
  logic  hit;
  way_t  hit_way;
  line_t hit_line;
  logic [`ICACHE_WAY_NUM-1:0] hit_vec;

  // ============================================================
  // stage 0
  // ============================================================

  assign s0_adef = |fetch_req_i.pc[BYTE_W-1:0];

  // invalidate wins over a fetch, nothing enters on a flush
  assign req_ready_o = s1_ready && !flush_i;
  assign acc_inv     = inv_req_i.valid && req_ready_o;
  assign acc_fetch   = fetch_req_i.valid && !inv_req_i.valid && req_ready_o;

  // hold stage 1's index while it stalls so the read data stays valid
  assign raddr_o = !s1_ready        ? s1_idx_q :
                   inv_req_i.valid ? inv_req_i.idx : idx_of(fetch_req_i.pc);

  // ============================================================
  // stage 1
  // ============================================================

  always_comb begin
    if (s1_inv_q) begin
      s1_ready = 1'b1;
    end else if (s1_fetch_q) begin
      s1_ready = rsp_fire;
    end else begin
      // empty, but a killed refill may still be draining
      s1_ready = (state_q == IDLE);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_fetch_q <= 1'b0;
      s1_inv_q   <= 1'b0;
    end else if (flush_i) begin
      s1_fetch_q <= 1'b0;
      s1_inv_q   <= 1'b0;
    end else if (s1_ready) begin
      s1_fetch_q <= acc_fetch;
      s1_inv_q   <= acc_inv;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_pc_q   <= fetch_req_i.pc;
      s1_adef_q <= s0_adef;
      s1_idx_q  <= inv_req_i.valid ? inv_req_i.idx : idx_of(fetch_req_i.pc);
      s1_way_q  <= inv_req_i.way;
    end
  end

  // tag match
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
      hit_vec[w] = s1_fetch_q && !s1_adef_q && valid_rdata_i[w] &&
                   (tag_rdata_i[w] == tag_of(s1_pc_q));
      if (hit_vec[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit      = |hit_vec;
  assign hit_line = data_rdata_i[hit_way];

  // misaligned pc answers at once with adef and a zero word
  always_comb begin
    fetch_rsp_o.valid = s1_fetch_q && (s1_adef_q || hit);
    fetch_rsp_o.pc    = s1_pc_q;
    fetch_rsp_o.adef  = s1_adef_q;
    fetch_rsp_o.instr = s1_adef_q ? '0 : hit_line[ofs_of(s1_pc_q)];
  end

  assign rsp_fire = fetch_rsp_o.valid && rsp_ready_i;

  // ============================================================
  // refill fsm
  // ============================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      victim_q   <= '0;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (s1_fetch_q && !s1_adef_q && !hit && !flush_i) begin
            state_q  <= MISS;
            victim_q <= plru_rdata_i;
          end
        end
        MISS: begin
          if (ar_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (r_i.valid && r_i.last) begin
            state_q <= DONE;
          end
        end
        // arrays written and reread here, hit path answers next cycle
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase

      if (state_q != REFILL) begin
        beat_cnt_q <= '0;
      end else if (r_i.valid) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == REFILL && r_i.valid) begin
      line_buf_q[beat_cnt_q] <= r_i.data;
    end
  end

  always_comb begin
    ar_o.valid = (state_q == MISS);
    ar_o.addr  = {s1_pc_q[`ADDR_W-1:OFS_W+BYTE_W], {(OFS_W + BYTE_W){1'b0}}};
    ar_o.len   = 8'(`ICACHE_LINE_WORDS - 1);
    ar_o.size  = `AXI_SIZE_WORD;
    ar_o.burst = `AXI_BURST_INCR;
  end

  assign r_ready_o = (state_q == REFILL);

  // ============================================================
  // array writes
  // ============================================================

  // a flushed fetch drains its burst but never fills the line
  assign refill_we = (state_q == DONE) && s1_fetch_q && !flush_i;

  always_comb begin
    for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
      tag_we_o[w]   = refill_we && (victim_q == way_t'(w));
      data_we_o[w]  = refill_we && (victim_q == way_t'(w));
      valid_we_o[w] = (refill_we && (victim_q == way_t'(w))) ||
                      (s1_inv_q && (s1_way_q == way_t'(w)));
    end
  end

  assign waddr_o       = s1_idx_q;
  assign tag_wdata_o   = tag_of(s1_pc_q);
  assign valid_wdata_o = !s1_inv_q;
  assign data_wdata_o  = line_buf_q;

  // point the victim away from the way that just hit
  assign plru_we_o    = rsp_fire && !s1_adef_q;
  assign plru_wdata_o = ~hit_way;

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr))
    else $error("ar valid dropped before ready");

  a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(hit_vec))
    else $error("line present in more than one way");

  a_no_rsp_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q inside {MISS, REFILL}) |-> !fetch_rsp_o.valid)
    else $error("response raised during refill");

endmodule

//--- src/icache_way_array.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_way_array import icache_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  idx_t                              raddr_i,
  input  idx_t                              waddr_i,
  input  logic [`ICACHE_WAY_NUM-1:0]        tag_we_i,
  input  logic [`ICACHE_WAY_NUM-1:0]        valid_we_i,
  input  logic [`ICACHE_WAY_NUM-1:0]        data_we_i,
  input  tag_t                              tag_wdata_i,
  input  logic                              valid_wdata_i,
  input  line_t                             data_wdata_i,
  input  logic                              plru_we_i,
  input  way_t                              plru_wdata_i,
  output tag_t  [`ICACHE_WAY_NUM-1:0]       tag_rdata_o,
  output logic  [`ICACHE_WAY_NUM-1:0]       valid_rdata_o,
  output line_t [`ICACHE_WAY_NUM-1:0]       data_rdata_o,
  output way_t                              plru_rdata_o
);

  // one tag, valid and data ram per way, all indexed by set
  for (genvar w = 0; w < `ICACHE_WAY_NUM; w++) begin : gen_way
    sdp_ram #(
      .WIDTH ($bits(tag_t)),
      .DEPTH (`ICACHE_SET_NUM)
    ) u_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (tag_we_i[w]),
      .waddr_i (waddr_i),
      .wdata_i (tag_wdata_i),
      .raddr_i (raddr_i),
      .rdata_o (tag_rdata_o[w])
    );

    sdp_ram #(
      .WIDTH (1),
      .DEPTH (`ICACHE_SET_NUM)
    ) u_valid_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (valid_we_i[w]),
      .waddr_i (waddr_i),
      .wdata_i (valid_wdata_i),
      .raddr_i (raddr_i),
      .rdata_o (valid_rdata_o[w])
    );

    sdp_ram #(
      .WIDTH ($bits(line_t)),
      .DEPTH (`ICACHE_SET_NUM)
    ) u_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (data_we_i[w]),
      .waddr_i (waddr_i),
      .wdata_i (data_wdata_i),
      .raddr_i (raddr_i),
      .rdata_o (data_rdata_o[w])
    );
  end

  // replacement bit names the victim way of the set
  sdp_ram #(
    .WIDTH ($bits(way_t)),
    .DEPTH (`ICACHE_SET_NUM)
  ) u_plru_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (plru_we_i),
    .waddr_i (waddr_i),
    .wdata_i (plru_wdata_i),
    .raddr_i (raddr_i),
    .rdata_o (plru_rdata_o)
  );

endmodule

//--- src/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // write first, a same-cycle write to the read address is forwarded
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem[waddr_i] <= wdata_i;
      end
      if (we_i && (waddr_i == raddr_i)) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem[raddr_i];
      end
    end
  end

  a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (raddr_i < DEPTH) && (!we_i || (waddr_i < DEPTH)))
    else $error("sdp_ram address beyond depth %0d", DEPTH);

endmodule

//--- src/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

  // address split, byte offset at the bottom
  localparam int BYTE_W = 2;
  localparam int OFS_W  = $clog2(`ICACHE_LINE_WORDS);
  localparam int IDX_W  = $clog2(`ICACHE_SET_NUM);
  localparam int TAG_W  = `ADDR_W - IDX_W - OFS_W - BYTE_W;
  localparam int WAY_W  = $clog2(`ICACHE_WAY_NUM);

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [31:0]        instr_t;
  typedef logic [IDX_W-1:0]   idx_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [OFS_W-1:0]   ofs_t;
  typedef logic [WAY_W-1:0]   way_t;
  typedef instr_t [`ICACHE_LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } fetch_req_t;

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_t instr;
    logic   adef;
  } fetch_rsp_t;

  // index invalidate of one way
  typedef struct packed {
    logic valid;
    idx_t idx;
    way_t way;
  } inv_req_t;

  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    logic   valid;
    instr_t data;
    logic   last;
  } axi_r_t;

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL,
    DONE
  } cache_state_e;

  function automatic idx_t idx_of(addr_t a);
    return a[BYTE_W+OFS_W +: IDX_W];
  endfunction

  function automatic tag_t tag_of(addr_t a);
    return a[`ADDR_W-1 -: TAG_W];
  endfunction

  function automatic ofs_t ofs_of(addr_t a);
    return a[BYTE_W +: OFS_W];
  endfunction

endpackage

//--- src/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ============================================================
// cache geometry
// ============================================================

// two ways only, the replacement state is one bit per set
`define ICACHE_WAY_NUM    2
`define ICACHE_SET_NUM    16
`define ICACHE_LINE_WORDS 4

`define ADDR_W            32

// ============================================================
// axi read channel codes
// ============================================================

`define AXI_BURST_INCR    2'b01
`define AXI_SIZE_WORD     3'b010

`endif
